// File: sio_delay_top.f
verilog/sio_delay_pkg.sv
verilog/sio_delay_regs.sv
verilog/data_delay_reset.sv
verilog/tap_delay_line.sv
verilog/sio_delay_top.sv
verif/sio_delay_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= sio_delay_tb
FILELIST  ?= sio_delay_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Regression passed

.PHONY: simulate clean

# the log decides the result, the simulator exit status is not used
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/sio_delay_tb.sv
`timescale 1ns/1ps

module sio_delay_tb
	import sio_delay_pkg::*;
();

	localparam int lanes = 4;
	localparam logic [adr_width-1:0] status_addr = adr_width'(lanes); // after the lane taps
	localparam int hist_depth = 40;
	localparam int cycle_limit = 3000; // tests need well under half of this

	logic                     clk;
	logic                     reset;
	logic                     wb_cyc;
	logic                     wb_stb;
	logic                     wb_we;
	logic [adr_width-1:0]     wb_adr;
	logic [wb_data_width-1:0] wb_dat_w;
	logic [wb_data_width-1:0] wb_dat_r;
	logic                     wb_ack;
	logic [lanes-1:0]         data_in;
	logic [lanes-1:0]         data_out;

	integer seed;
	int     errors;
	int     test_start_errors;
	int     tests_passed;
	int     tests_failed;
	int     cycle_count;

	logic [hist_depth-1:0] lane_hist [lanes]; // driven bits, newest at bit 0
	logic [tap_width-1:0]  exp_tap [lanes];   // tap the delay line should be using

	sio_delay_top #(
		.num_lanes (lanes)
	) i_dut (
		.clk      (clk),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.data_in  (data_in),
		.data_out (data_out)
	);

	always #50 clk = ~clk;

	// run limit
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("run timed out after %0d cycles", cycle_count);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[ERROR] %0t %s expected %0h got %0h", $time, name, expected, actual);
		errors++;
	endtask

	task automatic report_failure(input string what);
		$display("at time %0t: %s", $time, what);
		errors++;
	endtask

	task automatic report_test_result(input string name);
		if (errors == test_start_errors)
		begin
			tests_passed++;
			$display("test %s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - test_start_errors);
		end
	endtask

	// called on a falling edge, returns on the falling edge where ack is seen
	task automatic wb_transfer(input logic write, input logic [adr_width-1:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = write;
		wb_adr = adr;
		wb_dat_w = wdata;
		@(negedge clk);
		while (!wb_ack && waited < 4)
		begin
			@(negedge clk);
			waited++;
		end
		if (!wb_ack)
		begin
			report_failure($sformatf("no ack from bus at address %0h", adr));
		end
		rdata = wb_dat_r;
		wb_cyc = 1'b0; // master drops the request once ack is seen
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_write(input logic [adr_width-1:0] adr, input logic [31:0] wdata);
		logic [31:0] unused_data;
		wb_transfer(1'b1, adr, wdata, unused_data);
	endtask

	task automatic wb_read(input logic [adr_width-1:0] adr, output logic [31:0] rdata);
		wb_transfer(1'b0, adr, 32'h0, rdata);
	endtask

	// poll status until all busy bits are low, collecting every busy bit seen
	task automatic wait_idle(output logic [lanes-1:0] seen);
		logic [31:0] status;
		int reads;
		reads = 0;
		seen = '0;
		wb_read(status_addr, status);
		while (status != 0 && reads < 20)
		begin
			seen = seen | status[lanes-1:0];
			wb_read(status_addr, status);
			reads++;
		end
		if (status != 0)
		begin
			report_failure("busy bits in status never cleared");
		end
	endtask

	// random lane data, checked against the bit driven tap+1 cycles earlier
	task automatic run_lane_data(input int check_cycles);
		int warmup;
		warmup = max_tap + 2; // fills the model history past the deepest tap
		for (int c = 0; c < warmup + check_cycles; c++)
		begin
			if (c >= warmup)
			begin
				for (int l = 0; l < lanes; l++)
				begin
					if (data_out[l] !== lane_hist[l][exp_tap[l]])
					begin
						report_mismatch($sformatf("data_out[%0d]", l),
							32'(lane_hist[l][exp_tap[l]]), 32'(data_out[l]));
					end
				end
			end
			data_in = lanes'($random(seed));
			for (int l = 0; l < lanes; l++)
			begin
				lane_hist[l] = {lane_hist[l][hist_depth-2:0], data_in[l]};
			end
			@(negedge clk);
		end
	endtask

	task automatic reset_state();
		logic [31:0] rd;
		test_start_errors = errors;
		if (wb_ack !== 1'b0)
		begin
			report_mismatch("wb_ack", 32'h0, 32'(wb_ack));
		end
		if (data_out !== '0)
		begin
			report_mismatch("data_out", 32'h0, 32'(data_out));
		end
		for (int l = 0; l < lanes; l++)
		begin
			wb_read(adr_width'(l), rd);
			if (rd !== 32'h0)
			begin
				report_mismatch($sformatf("tap[%0d]", l), 32'h0, rd);
			end
		end
		// five status reads cover ten idle cycles
		for (int i = 0; i < 5; i++)
		begin
			wb_read(status_addr, rd);
			if (rd !== 32'h0)
			begin
				report_mismatch("status", 32'h0, rd);
			end
		end
		report_test_result("reset state");
	endtask

	task automatic register_access();
		logic [31:0] wr_vals [lanes];
		logic [31:0] rd;
		logic [lanes-1:0] seen;
		test_start_errors = errors;
		wr_vals[0] = 32'hFFFF_FFE7;
		wr_vals[1] = 32'h1234_5678;
		wr_vals[2] = 32'h0000_0003;
		wr_vals[3] = 32'hABCD_EF1F;
		for (int l = 0; l < lanes; l++)
		begin
			wb_write(adr_width'(l), wr_vals[l]);
		end
		for (int l = 0; l < lanes; l++)
		begin
			wb_read(adr_width'(l), rd);
			if (rd !== (wr_vals[l] & max_tap)) // only the tap bits are kept
			begin
				report_mismatch($sformatf("tap[%0d]", l), wr_vals[l] & max_tap, rd);
			end
		end
		wb_write(4'hC, 32'h0000_001F); // unmapped, acked and dropped
		wb_read(4'hC, rd);
		if (rd !== 32'h0)
		begin
			report_mismatch("unmapped word", 32'h0, rd);
		end
		wait_idle(seen);
		wb_write(status_addr, 32'hFFFF_FFFF);
		wb_read(status_addr, rd);
		if (rd !== 32'h0)
		begin
			report_mismatch("status", 32'h0, rd);
		end
		for (int l = 0; l < lanes; l++)
		begin
			exp_tap[l] = wr_vals[l][tap_width-1:0];
			wb_read(adr_width'(l), rd);
			if (rd !== 32'(exp_tap[l]))
			begin
				report_mismatch($sformatf("tap[%0d]", l), 32'(exp_tap[l]), rd);
			end
		end
		report_test_result("register access");
	endtask

	task automatic load_pulse_timing();
		logic [31:0] rd;
		int reads;
		int high_reads;
		int min_high;
		int max_high;
		logic found;
		logic ended;
		test_start_errors = errors;
		// a read samples busy once every two clocks
		min_high = (load_pulse_cycles - 1) / 2;
		max_high = (load_pulse_cycles + 1) / 2;
		wb_write(4'h0, 32'd21);
		exp_tap[0] = 5'd21;
		reads = 0;
		found = 1'b0;
		while (!found && reads < 8)
		begin
			wb_read(status_addr, rd);
			reads++;
			found = rd[0];
		end
		if (!found)
		begin
			report_failure("no load pulse on lane 0 after a tap write");
		end
		else
		begin
			high_reads = 1;
			ended = 1'b0;
			while (!ended && high_reads < 10)
			begin
				wb_read(status_addr, rd);
				if (rd[lanes-1:1] !== '0)
				begin
					report_mismatch("status of other lanes", 32'h0, rd & 32'hE);
				end
				if (rd[0])
				begin
					high_reads++;
				end
				else
				begin
					ended = 1'b1;
				end
			end
			if (high_reads < min_high || high_reads > max_high)
			begin
				report_failure($sformatf("load pulse seen high on %0d reads, allowed %0d to %0d",
					high_reads, min_high, max_high));
			end
		end
		// same value again, no pulse may follow
		wb_write(4'h0, 32'd21);
		for (int i = 0; i < 4; i++)
		begin
			wb_read(status_addr, rd);
			if (rd !== 32'h0)
			begin
				report_mismatch("status", 32'h0, rd);
			end
		end
		report_test_result("load pulse timing");
	endtask

	task automatic delayed_data();
		logic [tap_width-1:0] new_taps [lanes];
		logic [tap_width-1:0] tap;
		logic [lanes-1:0] seen;
		logic is_new;
		test_start_errors = errors;
		for (int l = 0; l < lanes; l++)
		begin
			is_new = 1'b0;
			while (!is_new)
			begin
				tap = tap_width'($random(seed));
				is_new = 1'b1;
				for (int k = 0; k < l; k++)
				begin
					if (new_taps[k] == tap)
					begin
						is_new = 1'b0;
					end
				end
			end
			new_taps[l] = tap;
			wb_write(adr_width'(l), 32'(tap));
		end
		wait_idle(seen);
		for (int l = 0; l < lanes; l++)
		begin
			exp_tap[l] = new_taps[l];
		end
		run_lane_data(100);
		report_test_result("delayed data");
	endtask

	task automatic rewrite_during_pulse();
		int case_lane [3] = '{1, 2, 0};
		logic [tap_width-1:0] first_tap [3] = '{5'd12, 5'd0, 5'd17};
		logic [tap_width-1:0] last_tap [3] = '{5'd0, 5'd31, 5'd17};
		logic [lanes-1:0] seen;
		logic [lanes-1:0] exp_seen;
		logic [31:0] rd;
		int lane;
		test_start_errors = errors;
		for (int c = 0; c < 3; c++)
		begin
			lane = case_lane[c];
			exp_seen = '0;
			if (first_tap[c] != exp_tap[lane] || last_tap[c] != exp_tap[lane])
			begin
				exp_seen[lane] = 1'b1;
			end
			// back to back, the second write lands inside the first pulse
			wb_write(adr_width'(lane), 32'(first_tap[c]));
			wb_write(adr_width'(lane), 32'(last_tap[c]));
			wait_idle(seen);
			if (seen !== exp_seen)
			begin
				report_mismatch("busy bits seen", 32'(exp_seen), 32'(seen));
			end
			exp_tap[lane] = last_tap[c];
			wb_read(adr_width'(lane), rd);
			if (rd !== 32'(last_tap[c]))
			begin
				report_mismatch($sformatf("tap[%0d]", lane), 32'(last_tap[c]), rd);
			end
			run_lane_data(50);
		end
		report_test_result("rewrite during pulse");
	endtask

	initial
	begin
		seed = 32'h7f3ccc78;
		errors = 0;
		test_start_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		cycle_count = 0;
		clk = 1'b0;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		data_in = '0;
		for (int l = 0; l < lanes; l++)
		begin
			lane_hist[l] = '0;
			exp_tap[l] = '0;
		end
		repeat (5) @(negedge clk);
		reset = 1'b0;

		reset_state();
		register_access();
		load_pulse_timing();
		delayed_data();
		rewrite_during_pulse();

		$display("tests passed %0d, tests failed %0d, errors %0d",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
		begin
			$display("Regression passed");
		end
		else
		begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: verilog/sio_delay_top.sv
`timescale 1ns/1ps

module sio_delay_top
	import sio_delay_pkg::*;
#(
	parameter int num_lanes = num_lanes_default // 1 to 8 lanes
)
(
	input  logic                     clk,
	input  logic                     reset,

	// wishbone classic slave
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  logic [adr_width-1:0]     wb_adr,
	input  logic [wb_data_width-1:0] wb_dat_w,
	output logic [wb_data_width-1:0] wb_dat_r,
	output logic                     wb_ack,

	// lane data
	input  logic [num_lanes-1:0]     data_in,
	output logic [num_lanes-1:0]     data_out
);

	logic [num_lanes*tap_width-1:0] delay_tap;
	logic [num_lanes-1:0]           delay_data_reset; // also the busy status

	sio_delay_regs #(
		.num_lanes (num_lanes)
	) i_regs (
		.clk       (clk),
		.reset     (reset),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.busy      (delay_data_reset),
		.delay_tap (delay_tap)
	);

	// one reset generator and one delay line per lane
	generate
		for (genvar g = 0; g < num_lanes; g++)
		begin : lane
			data_delay_reset i_reset_gen (
				.clk              (clk),
				.reset            (reset),
				.delay_tap        (delay_tap[g*tap_width +: tap_width]),
				.delay_data_reset (delay_data_reset[g])
			);

			tap_delay_line i_delay_line (
				.clk              (clk),
				.reset            (reset),
				.data_in          (data_in[g]),
				.delay_tap        (delay_tap[g*tap_width +: tap_width]),
				.delay_data_reset (delay_data_reset[g]),
				.data_out         (data_out[g])
			);
		end
	endgenerate

endmodule

// File: verilog/tap_delay_line.sv
`timescale 1ns/1ps

module tap_delay_line
	import sio_delay_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 data_in,          // lane bit from the pins
	input  logic [tap_width-1:0] delay_tap,        // requested tap
	input  logic                 delay_data_reset, // load window from the reset generator
	output logic                 data_out          // delayed lane bit
);

	// one tap is one clock
	// total delay is applied_tap plus the output register

	logic [max_tap-1:0]   history;     // past input bits, newest at bit 0
	logic [max_tap:0]     tap_view;    // live input followed by the history
	logic [tap_width-1:0] applied_tap; // tap currently in use

	// entry k of the view is the input from k clocks ago
	assign tap_view = {history, data_in};

	// applied tap follows the request only inside the load window
	// so it holds the value from the last load cycle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			applied_tap <= '0;
		end
		else if (delay_data_reset)
		begin
			applied_tap <= delay_tap;
		end
	end

	// history shifts every clock, data is never stalled
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			history <= '0;
		end
		else
		begin
			history <= tap_view[max_tap-1:0]; // drop the oldest bit
		end
	end

	// pick the bit from applied_tap clocks ago
	// many data bits are in flight at once
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			data_out <= 1'b0;
		end
		else
		begin
			data_out <= tap_view[applied_tap];
		end
	end

endmodule

// File: verilog/data_delay_reset.sv
`timescale 1ns/1ps

module data_delay_reset
	import sio_delay_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic [tap_width-1:0] delay_tap,       // tap from the register block
	output logic                 delay_data_reset // load pulse, active high
);

	localparam logic state_idle = 1'b0;
	localparam logic state_active = 1'b1;

	// counter value on the last high cycle of the pulse
	localparam logic [pulse_cnt_width-1:0] last_count =
		pulse_cnt_width'(load_pulse_cycles - 1);

	logic                       state;
	logic [tap_width-1:0]       curr_delay_tap; // tap last handed to the delay line
	logic [pulse_cnt_width-1:0] counter;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= state_idle;
			curr_delay_tap <= '0;
			counter <= '0;
			delay_data_reset <= 1'b0;
		end
		else
		begin
			case (state)
				state_idle:
				begin
					counter <= '0;
					if (delay_tap != curr_delay_tap)
					begin
						// tap changed, start the load pulse
						delay_data_reset <= 1'b1;
						state <= state_active;
					end
					else
					begin
						delay_data_reset <= 1'b0;
					end
				end

				state_active:
				begin
					if (counter < last_count)
					begin
						delay_data_reset <= 1'b1;
						counter <= counter + 1'b1;
					end
					else
					begin
						// end of pulse, later writes are seen back in idle
						delay_data_reset <= 1'b0;
						counter <= '0;
						curr_delay_tap <= delay_tap;
						state <= state_idle;
					end
				end
			endcase
		end
	end

endmodule

// File: verilog/sio_delay_regs.sv
`timescale 1ns/1ps

module sio_delay_regs
	import sio_delay_pkg::*;
#(
	parameter int num_lanes = num_lanes_default
)
(
	input  logic                           clk,
	input  logic                           reset,

	// wishbone classic slave
	input  logic                           wb_cyc,
	input  logic                           wb_stb,
	input  logic                           wb_we,
	input  logic [adr_width-1:0]           wb_adr,
	input  logic [wb_data_width-1:0]       wb_dat_w,
	output logic [wb_data_width-1:0]       wb_dat_r,
	output logic                           wb_ack,

	// lane side
	input  logic [num_lanes-1:0]           busy,     // load pulses, one per lane
	output logic [num_lanes*tap_width-1:0] delay_tap // lane taps, lane 0 lowest
);

	logic [tap_width-1:0]     tap_reg [num_lanes];
	logic                     req;
	logic                     hit_status;
	logic [num_lanes-1:0]     hit_lane;
	logic [wb_data_width-1:0] rd_data;

	// new request only while ack is low, so each transfer gets one ack
	assign req = wb_cyc & wb_stb & ~wb_ack;

	assign hit_status = (wb_adr == status_addr_offset(num_lanes));

	// word address decode for the tap registers
	always_comb
	begin
		for (int i = 0; i < num_lanes; i++)
		begin
			hit_lane[i] = (wb_adr == adr_width'(i));
		end
	end

	// read mux, unmapped words read as zero
	always_comb
	begin
		rd_data = '0;
		for (int i = 0; i < num_lanes; i++)
		begin
			if (hit_lane[i])
			begin
				rd_data[tap_width-1:0] = tap_reg[i];
			end
		end
		if (hit_status)
		begin
			rd_data[num_lanes-1:0] = busy;
		end
	end

	// single cycle ack, also for unmapped addresses
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wb_ack <= 1'b0;
		end
		else
		begin
			wb_ack <= req;
		end
	end

	// tap writes land on the edge that raises ack
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < num_lanes; i++)
			begin
				tap_reg[i] <= '0;
			end
		end
		else if (req && wb_we)
		begin
			for (int i = 0; i < num_lanes; i++)
			begin
				if (hit_lane[i])
				begin
					tap_reg[i] <= wb_dat_w[tap_width-1:0]; // upper bits dropped
				end
			end
		end
	end

	// read data held while ack is high
	always_ff @(posedge clk)
	begin
		if (req)
		begin
			wb_dat_r <= rd_data;
		end
	end

	// flatten the taps for the lanes
	generate
		for (genvar g = 0; g < num_lanes; g++)
		begin : tap_out
			assign delay_tap[g*tap_width +: tap_width] = tap_reg[g];
		end
	endgenerate

endmodule

// File: verilog/sio_delay_pkg.sv
package sio_delay_pkg;

	// lane tap settings
	localparam int tap_width = 5;
	localparam int max_tap = (1 << tap_width) - 1; // 31 taps, one clock each

	// load pulse seen by the delay line after a tap change
	localparam int load_pulse_cycles = 4;
	localparam int pulse_cnt_width = $clog2(load_pulse_cycles + 1);

	// wishbone side
	localparam int adr_width = 4; // word address
	localparam int wb_data_width = 32;

	// lane count used when the top level is not overridden
	localparam int num_lanes_default = 4;

	// lane tap words sit at 0 .. lanes-1
	// the busy status word follows the last lane tap word
	function automatic logic [adr_width-1:0] status_addr_offset(input int lanes);
		return adr_width'(lanes);
	endfunction

endpackage
